// ==== hyper_pkg.sv ====
package hyper_pkg;

    localparam int CA_WORDS = 3;  // Command/address words per transaction
    localparam int CA_SEL_W = 2;

    typedef logic [15:0] hyper_word_t;
    typedef logic [1:0]  hyper_mask_t;  // High bit keeps the byte
    typedef logic [31:0] hyper_addr_t;  // Word address
    typedef logic [11:0] burst_len_t;
    typedef logic [3:0]  lat_cnt_t;

    typedef struct packed {
        hyper_addr_t address;
        logic        write;
        burst_len_t  burst;       // Words, never zero
        logic        burst_type;  // High for linear
    } hyper_trans_t;

    typedef struct packed {
        lat_cnt_t t_acc;  // Initial access latency in clocks
        lat_cnt_t t_rwr;  // Read/write recovery in clocks
    } hyper_cfg_t;

    typedef enum logic [3:0] {
        IDLE,
        CMD_ADDR,
        LATENCY,
        DATA_W,
        WAIT_W,
        DATA_R,
        WAIT_R,
        RECOVER
    } seq_state_t;

endpackage

// ==== hyper_seq.sv ====
`timescale 1ns/1ps

module hyper_seq (
    input  logic                           clk0,
    input  logic                           rst_ni,
    input  logic                           trans_valid_i,
    input  hyper_pkg::hyper_trans_t        trans_i,
    output logic                           trans_ready_o,
    input  hyper_pkg::hyper_cfg_t          cfg_i,
    input  logic                           tx_valid_i,
    output logic                           tx_ready_o,
    input  logic                           rx_ready_i,
    input  logic                           rx_afull_i,
    input  logic                           wr_valid_i,
    input  logic                           hyper_rwds_i,
    output logic                           rx_flush_o,
    output logic [hyper_pkg::CA_SEL_W-1:0] ca_sel_o,
    output logic                           data_mode_o,
    output hyper_pkg::hyper_trans_t        trans_o,
    output logic                           hyper_cs_no,
    output logic                           hyper_ck_en_o,
    output logic                           hyper_dq_oe_o,
    output logic                           rx_last_o,
    output logic                           b_valid_o
);

    hyper_pkg::seq_state_t          state_q;
    hyper_pkg::hyper_trans_t        trans_q;
    hyper_pkg::lat_cnt_t            lat_cnt_q;    // Latency, then recovery
    hyper_pkg::burst_len_t          burst_cnt_q;  // Words still to accept or capture
    logic [hyper_pkg::CA_SEL_W-1:0] ca_sel_q;
    logic                           add_lat_q;
    logic                           b_valid_q;
    logic                           lat_last;
    logic                           wr_phase;
    logic                           rd_phase;
    logic                           rd_go;
    logic                           wr_done;

    assign lat_last = state_q == hyper_pkg::LATENCY && lat_cnt_q == '0 && !add_lat_q;
    assign wr_phase = state_q == hyper_pkg::DATA_W || state_q == hyper_pkg::WAIT_W;
    assign rd_phase = state_q == hyper_pkg::DATA_R || state_q == hyper_pkg::WAIT_R;

    // Clock the device only with room for the word in flight as well
    assign rd_go = rx_ready_i && !rx_afull_i && !hyper_rwds_i &&
                   burst_cnt_q > hyper_pkg::burst_len_t'(state_q == hyper_pkg::DATA_R);

    assign wr_done = state_q == hyper_pkg::DATA_W && burst_cnt_q == '0 && wr_valid_i;

    always_ff @(posedge clk0) begin
        if (trans_valid_i && trans_ready_o) begin
            trans_q <= trans_i;
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= hyper_pkg::IDLE;
            lat_cnt_q <= '0;
            ca_sel_q  <= '0;
            add_lat_q <= 1'b0;
        end else begin
            case (state_q)
                hyper_pkg::IDLE: begin
                    ca_sel_q <= '0;
                    if (trans_valid_i) begin
                        state_q <= hyper_pkg::CMD_ADDR;
                    end
                end
                hyper_pkg::CMD_ADDR: begin
                    if (ca_sel_q == hyper_pkg::CA_SEL_W'(hyper_pkg::CA_WORDS - 1)) begin
                        add_lat_q <= hyper_rwds_i;  // Device asks for double latency
                        lat_cnt_q <= cfg_i.t_acc - 1'b1;
                        state_q   <= hyper_pkg::LATENCY;
                    end else begin
                        ca_sel_q <= ca_sel_q + 1'b1;
                    end
                end
                hyper_pkg::LATENCY: begin
                    if (lat_cnt_q != '0) begin
                        lat_cnt_q <= lat_cnt_q - 1'b1;
                    end else if (add_lat_q) begin
                        add_lat_q <= 1'b0;
                        lat_cnt_q <= cfg_i.t_acc - 1'b1;
                    end else if (trans_q.write) begin
                        state_q <= tx_valid_i ? hyper_pkg::DATA_W : hyper_pkg::WAIT_W;
                    end else begin
                        state_q <= rd_go ? hyper_pkg::DATA_R : hyper_pkg::WAIT_R;
                    end
                end
                hyper_pkg::DATA_W, hyper_pkg::WAIT_W: begin
                    if (wr_done) begin
                        lat_cnt_q <= cfg_i.t_rwr;
                        state_q   <= hyper_pkg::RECOVER;
                    end else if (tx_valid_i && tx_ready_o) begin
                        state_q <= hyper_pkg::DATA_W;
                    end else begin
                        state_q <= hyper_pkg::WAIT_W;
                    end
                end
                hyper_pkg::DATA_R, hyper_pkg::WAIT_R: begin
                    // Hold cs until the buffer has drained
                    if (burst_cnt_q == '0 && !rx_afull_i) begin
                        lat_cnt_q <= cfg_i.t_rwr;
                        state_q   <= hyper_pkg::RECOVER;
                    end else begin
                        state_q <= rd_go ? hyper_pkg::DATA_R : hyper_pkg::WAIT_R;
                    end
                end
                hyper_pkg::RECOVER: begin
                    if (lat_cnt_q <= hyper_pkg::lat_cnt_t'(1)) begin
                        state_q <= hyper_pkg::IDLE;
                    end else begin
                        lat_cnt_q <= lat_cnt_q - 1'b1;
                    end
                end
                default: state_q <= hyper_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            burst_cnt_q <= '0;
        end else if (trans_valid_i && trans_ready_o) begin
            burst_cnt_q <= trans_i.burst;
        end else if ((tx_valid_i && tx_ready_o) || (rd_phase && hyper_rwds_i)) begin
            burst_cnt_q <= burst_cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            b_valid_q <= 1'b0;
        end else begin
            b_valid_q <= wr_done;  // Cycle after the last word
        end
    end

    assign trans_ready_o = state_q == hyper_pkg::IDLE;
    assign tx_ready_o    = trans_q.write && (lat_last || (wr_phase && burst_cnt_q != '0));
    assign hyper_cs_no   = state_q == hyper_pkg::IDLE || state_q == hyper_pkg::RECOVER;
    assign hyper_ck_en_o = state_q inside {hyper_pkg::CMD_ADDR, hyper_pkg::LATENCY,
                                           hyper_pkg::DATA_W, hyper_pkg::DATA_R};
    assign hyper_dq_oe_o = state_q == hyper_pkg::CMD_ADDR || wr_phase;
    assign data_mode_o   = wr_phase;
    assign rx_flush_o    = !rd_phase;
    assign rx_last_o     = burst_cnt_q == hyper_pkg::burst_len_t'(1);
    assign ca_sel_o      = ca_sel_q;
    assign trans_o       = trans_q;
    assign b_valid_o     = b_valid_q;

endmodule

// ==== hyper_tx.sv ====
`timescale 1ns/1ps

module hyper_tx (
    input  logic                           clk0,
    input  logic                           rst_ni,
    input  hyper_pkg::hyper_trans_t        trans_i,
    input  logic [hyper_pkg::CA_SEL_W-1:0] ca_sel_i,
    input  logic                           data_mode_i,
    input  logic                           tx_valid_i,
    input  logic                           tx_ready_i,
    input  hyper_pkg::hyper_word_t         tx_data_i,
    input  hyper_pkg::hyper_mask_t         tx_mask_i,
    output logic                           wr_valid_o,
    output hyper_pkg::hyper_word_t         hyper_dq_o,
    output hyper_pkg::hyper_mask_t         hyper_mask_o
);

    logic [47:0]            cmd_addr;
    hyper_pkg::hyper_word_t ca_word;
    hyper_pkg::hyper_word_t wr_data_q;
    hyper_pkg::hyper_mask_t wr_mask_q;
    logic                   wr_valid_q;

    always_comb begin
        cmd_addr        = '0;
        cmd_addr[47]    = !trans_i.write;  // Read
        cmd_addr[45]    = trans_i.burst_type;
        cmd_addr[44:16] = trans_i.address[31:3];  // Row and upper column
        cmd_addr[2:0]   = trans_i.address[2:0];
    end

    always_comb begin
        case (ca_sel_i)
            2'd0:    ca_word = cmd_addr[47:32];
            2'd1:    ca_word = cmd_addr[31:16];
            default: ca_word = cmd_addr[15:0];
        endcase
    end

    always_ff @(posedge clk0) begin
        if (tx_valid_i && tx_ready_i) begin
            wr_data_q <= tx_data_i;
            wr_mask_q <= tx_mask_i;
        end
    end

    // Full for the one cycle the word is on the bus
    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_valid_q <= 1'b0;
        end else begin
            wr_valid_q <= tx_valid_i && tx_ready_i;
        end
    end

    assign wr_valid_o   = wr_valid_q;
    assign hyper_dq_o   = data_mode_i ? wr_data_q : ca_word;
    assign hyper_mask_o = data_mode_i ? wr_mask_q : '0;

endmodule

// ==== hyper_rx.sv ====
`timescale 1ns/1ps

module hyper_rx (
    input  logic                   clk0,
    input  logic                   rst_ni,
    input  hyper_pkg::hyper_word_t hyper_dq_i,
    input  logic                   hyper_rwds_i,
    input  logic                   last_i,
    input  logic                   flush_i,
    input  logic                   rx_ready_i,
    output logic                   rx_valid_o,
    output hyper_pkg::hyper_word_t rx_data_o,
    output logic                   rx_last_o,
    output logic                   afull_o
);

    typedef struct packed {
        logic                   last;
        hyper_pkg::hyper_word_t data;
    } rx_entry_t;

    rx_entry_t  buf_q [2];  // Second slot takes the word in flight
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic       push;
    logic       pop;

    assign push = hyper_rwds_i && !flush_i;
    assign pop  = rx_valid_o && rx_ready_i;

    always_ff @(posedge clk0) begin
        if (push) begin
            buf_q[wr_ptr_q] <= '{last: last_i, data: hyper_dq_i};
        end
    end

    always_ff @(posedge clk0 or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= !rd_ptr_q;
            end
            count_q <= count_q + {1'b0, push} - {1'b0, pop};
        end
    end

    assign rx_valid_o = count_q != '0;
    assign rx_data_o  = buf_q[rd_ptr_q].data;
    assign rx_last_o  = buf_q[rd_ptr_q].last;
    assign afull_o    = count_q != '0;  // One word ahead of full

endmodule

// ==== hyper_ctrl.sv ====
`timescale 1ns/1ps

module hyper_ctrl (
    input  logic                    clk0,
    input  logic                    rst_ni,
    input  logic                    trans_valid_i,
    input  hyper_pkg::hyper_trans_t trans_i,
    output logic                    trans_ready_o,
    input  hyper_pkg::hyper_cfg_t   cfg_i,
    input  logic                    tx_valid_i,
    input  hyper_pkg::hyper_word_t  tx_data_i,
    input  hyper_pkg::hyper_mask_t  tx_mask_i,
    output logic                    tx_ready_o,
    output logic                    rx_valid_o,
    output hyper_pkg::hyper_word_t  rx_data_o,
    output logic                    rx_last_o,
    input  logic                    rx_ready_i,
    output logic                    b_valid_o,
    output logic                    hyper_cs_no,
    output logic                    hyper_ck_en_o,
    output hyper_pkg::hyper_word_t  hyper_dq_o,
    output hyper_pkg::hyper_mask_t  hyper_mask_o,
    output logic                    hyper_dq_oe_o,
    input  hyper_pkg::hyper_word_t  hyper_dq_i,
    input  logic                    hyper_rwds_i
);

    hyper_pkg::hyper_trans_t        trans_q;
    logic [hyper_pkg::CA_SEL_W-1:0] ca_sel;
    logic                           data_mode;
    logic                           wr_valid;
    logic                           rx_flush;
    logic                           rx_afull;
    logic                           rx_last_tag;  // Tag written with each read word

    hyper_seq i_hyper_seq (
        .clk0          ( clk0          ),
        .rst_ni        ( rst_ni        ),
        .trans_valid_i ( trans_valid_i ),
        .trans_i       ( trans_i       ),
        .trans_ready_o ( trans_ready_o ),
        .cfg_i         ( cfg_i         ),
        .tx_valid_i    ( tx_valid_i    ),
        .tx_ready_o    ( tx_ready_o    ),
        .rx_ready_i    ( rx_ready_i    ),
        .rx_afull_i    ( rx_afull      ),
        .wr_valid_i    ( wr_valid      ),
        .hyper_rwds_i  ( hyper_rwds_i  ),
        .rx_flush_o    ( rx_flush      ),
        .ca_sel_o      ( ca_sel        ),
        .data_mode_o   ( data_mode     ),
        .trans_o       ( trans_q       ),
        .hyper_cs_no   ( hyper_cs_no   ),
        .hyper_ck_en_o ( hyper_ck_en_o ),
        .hyper_dq_oe_o ( hyper_dq_oe_o ),
        .rx_last_o     ( rx_last_tag   ),
        .b_valid_o     ( b_valid_o     )
    );

    hyper_tx i_hyper_tx (
        .clk0         ( clk0         ),
        .rst_ni       ( rst_ni       ),
        .trans_i      ( trans_q      ),
        .ca_sel_i     ( ca_sel       ),
        .data_mode_i  ( data_mode    ),
        .tx_valid_i   ( tx_valid_i   ),
        .tx_ready_i   ( tx_ready_o   ),
        .tx_data_i    ( tx_data_i    ),
        .tx_mask_i    ( tx_mask_i    ),
        .wr_valid_o   ( wr_valid     ),
        .hyper_dq_o   ( hyper_dq_o   ),
        .hyper_mask_o ( hyper_mask_o )
    );

    hyper_rx i_hyper_rx (
        .clk0         ( clk0         ),
        .rst_ni       ( rst_ni       ),
        .hyper_dq_i   ( hyper_dq_i   ),
        .hyper_rwds_i ( hyper_rwds_i ),
        .last_i       ( rx_last_tag  ),
        .flush_i      ( rx_flush     ),
        .rx_ready_i   ( rx_ready_i   ),
        .rx_valid_o   ( rx_valid_o   ),
        .rx_data_o    ( rx_data_o    ),
        .rx_last_o    ( rx_last_o    ),
        .afull_o      ( rx_afull     )
    );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk0_o
);

    localparam time HALF_PERIOD = 50ns;  // 100 ns period

    initial begin
        clk0_o = 1'b0;
    end

    always #(HALF_PERIOD) clk0_o = ~clk0_o;

endmodule

// ==== hyper_ram_model.sv ====
`timescale 1ns/1ps

module hyper_ram_model (
    input  logic                   clk0,
    input  logic                   cs_ni,
    input  logic                   ck_en_i,
    input  hyper_pkg::hyper_word_t dq_i,
    input  hyper_pkg::hyper_mask_t mask_i,
    input  logic                   extra_lat_i,
    input  hyper_pkg::lat_cnt_t    t_acc_i,
    output hyper_pkg::hyper_word_t dq_o,
    output logic                   rwds_o
);

    hyper_pkg::hyper_word_t mem [64];
    logic [1:0]             ca_cnt_q;   // 3 once command/address is complete
    logic [31:0]            ca_q;       // First two words
    logic [5:0]             addr_q;
    logic                   write_q;
    logic [4:0]             lat_q;
    logic                   rd_valid_q;
    hyper_pkg::hyper_word_t rd_data_q;
    logic [4:0]             lat_need;
    logic [47:0]            ca_full;

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 16'(i * 16'h1357) ^ 16'hc3a5;
        end
    end

    assign lat_need = extra_lat_i ? {t_acc_i, 1'b0} : {1'b0, t_acc_i};
    assign ca_full  = {ca_q, dq_i};

    always @(posedge clk0) begin
        rd_valid_q <= 1'b0;
        if (cs_ni) begin
            ca_cnt_q <= '0;
            lat_q    <= '0;
        end else if (ck_en_i) begin
            if (ca_cnt_q != 2'd3) begin
                ca_q     <= {ca_q[15:0], dq_i};
                ca_cnt_q <= ca_cnt_q + 2'd1;
                if (ca_cnt_q == 2'd2) begin
                    addr_q  <= {ca_full[18:16], ca_full[2:0]};
                    write_q <= !ca_full[47];
                end
            end else if (lat_q < lat_need) begin
                lat_q <= lat_q + 5'd1;
            end else if (write_q) begin
                if (!mask_i[0]) begin
                    mem[addr_q][7:0] <= dq_i[7:0];
                end
                if (!mask_i[1]) begin
                    mem[addr_q][15:8] <= dq_i[15:8];
                end
                addr_q <= addr_q + 6'd1;
            end else begin
                rd_data_q  <= mem[addr_q];  // Word appears in the next cycle
                rd_valid_q <= 1'b1;
                addr_q     <= addr_q + 6'd1;
            end
        end
    end

    // Additional latency request while command/address runs
    assign rwds_o = rd_valid_q || (!cs_ni && ca_cnt_q != 2'd3 && extra_lat_i);
    assign dq_o   = rd_data_q;

endmodule

// ==== tb_hyper.sv ====
`timescale 1ns/1ps

module tb_hyper;

    localparam int N_TRANS   = 40;
    localparam int MAX_CYCLE = N_TRANS * 80;

    logic                    clk0;
    logic                    rst_ni;
    logic                    trans_valid;
    hyper_pkg::hyper_trans_t trans;
    logic                    trans_ready;
    hyper_pkg::hyper_cfg_t   cfg;
    logic                    tx_valid;
    hyper_pkg::hyper_word_t  tx_data;
    hyper_pkg::hyper_mask_t  tx_mask;
    logic                    tx_ready;
    logic                    rx_valid;
    hyper_pkg::hyper_word_t  rx_data;
    logic                    rx_last;
    logic                    rx_ready;
    logic                    b_valid;
    logic                    cs_n;
    logic                    ck_en;
    hyper_pkg::hyper_word_t  dq_out;
    hyper_pkg::hyper_mask_t  mask_out;
    logic                    dq_oe;
    hyper_pkg::hyper_word_t  dq_in;
    logic                    rwds;
    logic                    extra_lat;

    integer                  seed;
    int                      checks;
    int                      errors;
    int                      cycles;
    hyper_pkg::hyper_word_t  ref_mem [64];

    // Monitor state
    hyper_pkg::hyper_trans_t exp_trans;
    int                      mon_ca;
    logic                    lat_seen;
    int                      lat_cnt;
    int                      hi_cnt;
    int                      wr_idx;
    int                      rd_cnt;
    int                      b_cnt;

    tb_clk_gen i_tb_clk_gen (
        .clk0_o ( clk0 )
    );

    hyper_ctrl i_hyper_ctrl (
        .clk0          ( clk0        ),
        .rst_ni        ( rst_ni      ),
        .trans_valid_i ( trans_valid ),
        .trans_i       ( trans       ),
        .trans_ready_o ( trans_ready ),
        .cfg_i         ( cfg         ),
        .tx_valid_i    ( tx_valid    ),
        .tx_data_i     ( tx_data     ),
        .tx_mask_i     ( tx_mask     ),
        .tx_ready_o    ( tx_ready    ),
        .rx_valid_o    ( rx_valid    ),
        .rx_data_o     ( rx_data     ),
        .rx_last_o     ( rx_last     ),
        .rx_ready_i    ( rx_ready    ),
        .b_valid_o     ( b_valid     ),
        .hyper_cs_no   ( cs_n        ),
        .hyper_ck_en_o ( ck_en       ),
        .hyper_dq_o    ( dq_out      ),
        .hyper_mask_o  ( mask_out    ),
        .hyper_dq_oe_o ( dq_oe       ),
        .hyper_dq_i    ( dq_in       ),
        .hyper_rwds_i  ( rwds        )
    );

    hyper_ram_model i_hyper_ram_model (
        .clk0        ( clk0      ),
        .cs_ni       ( cs_n      ),
        .ck_en_i     ( ck_en     ),
        .dq_i        ( dq_out    ),
        .mask_i      ( mask_out  ),
        .extra_lat_i ( extra_lat ),
        .t_acc_i     ( cfg.t_acc ),
        .dq_o        ( dq_in     ),
        .rwds_o      ( rwds      )
    );

    function automatic hyper_pkg::hyper_word_t ca_word(hyper_pkg::hyper_trans_t t, int idx);
        logic [47:0] ca;
        ca        = '0;
        ca[47]    = !t.write;
        ca[45]    = t.burst_type;
        ca[44:16] = t.address[31:3];
        ca[2:0]   = t.address[2:0];
        return ca[47 - 16 * idx -: 16];
    endfunction

    // High mask bit keeps the old byte
    function automatic hyper_pkg::hyper_word_t masked_word(hyper_pkg::hyper_word_t old_w,
                                                           hyper_pkg::hyper_word_t new_w,
                                                           hyper_pkg::hyper_mask_t mask);
        hyper_pkg::hyper_word_t res;
        res[7:0]  = mask[0] ? old_w[7:0] : new_w[7:0];
        res[15:8] = mask[1] ? old_w[15:8] : new_w[15:8];
        return res;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // Compare process
    always @(posedge clk0) begin
        if (rst_ni) begin
            if (trans_valid && trans_ready) begin
                exp_trans = trans;
                mon_ca    = 0;
                lat_seen  = 1'b0;
                lat_cnt   = 0;
                wr_idx    = 0;
                rd_cnt    = 0;
                b_cnt     = 0;
            end else if (!cs_n && mon_ca < 3) begin
                check("ca_enable", 2'b11, {ck_en, dq_oe});
                check("ca_word", ca_word(exp_trans, mon_ca), dq_out);
                if (mon_ca == 0) begin
                    check("recovery_gap", 1, hi_cnt >= int'(cfg.t_rwr));
                end
                mon_ca++;
            end else if (!cs_n && !lat_seen) begin
                if (exp_trans.write ? (ck_en && dq_oe) : rwds) begin
                    // A read also counts the clock that launched the first word
                    check("latency", (extra_lat ? 2 : 1) * int'(cfg.t_acc)
                          + (exp_trans.write ? 0 : 1), lat_cnt);
                    lat_seen = 1'b1;
                end else if (ck_en) begin
                    lat_cnt++;
                end
            end
            hi_cnt = cs_n ? hi_cnt + 1 : 0;
            if (tx_valid && tx_ready) begin
                ref_mem[6'(exp_trans.address[5:0] + wr_idx)] =
                    masked_word(ref_mem[6'(exp_trans.address[5:0] + wr_idx)], tx_data, tx_mask);
                wr_idx++;
            end
            if (rx_valid && rx_ready) begin
                check("read_data", ref_mem[6'(exp_trans.address[5:0] + rd_cnt)], rx_data);
                check("rx_last", rd_cnt == int'(exp_trans.burst) - 1, rx_last);
                rd_cnt++;
            end
            if (b_valid) begin
                b_cnt++;
            end
        end
    end

    always @(posedge clk0) begin
        cycles++;
        if (cycles >= MAX_CYCLE) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLE);
            $display("Simulation failed");
            $finish;
        end
    end

    // Entered on a falling edge, so the request meets the first IDLE cycle
    task automatic issue(input logic write, input logic [31:0] addr, input int len);
        trans.address    = addr;
        trans.write      = write;
        trans.burst      = 12'(len);
        trans.burst_type = 1'b1;
        trans_valid      = 1'b1;
        @(posedge clk0);
        while (!trans_ready) @(posedge clk0);
        @(negedge clk0);
        trans_valid = 1'b0;
    endtask

    task automatic write_burst(input logic [31:0] addr, input int len);
        issue(1'b1, addr, len);
        for (int i = 0; i < len; i++) begin
            repeat ($unsigned($random(seed)) % 3) @(negedge clk0);
            tx_valid = 1'b1;
            tx_data  = 16'($random(seed));
            tx_mask  = 2'($random(seed));
            @(posedge clk0);
            while (!tx_ready) @(posedge clk0);
            @(negedge clk0);
            tx_valid = 1'b0;
        end
        while (b_cnt == 0) @(negedge clk0);
        while (!trans_ready) @(negedge clk0);
        check("b_valid_count", 1, b_cnt);
    endtask

    task automatic read_burst(input logic [31:0] addr, input int len);
        issue(1'b0, addr, len);
        while (rd_cnt < len) begin
            @(negedge clk0);
            rx_ready = ($unsigned($random(seed)) % 4) != 0;  // Mostly ready
        end
        rx_ready = 1'b1;
        while (!trans_ready) @(negedge clk0);
        check("read_count", len, rd_cnt);
        check("b_valid_count", 0, b_cnt);
    endtask

    initial begin
        logic [31:0] addr;
        int          len;
        seed        = 32'h978babb9;
        checks      = 0;
        errors      = 0;
        cycles      = 0;
        hi_cnt      = 99;
        rst_ni      = 1'b0;
        trans_valid = 1'b0;
        trans       = '0;
        cfg.t_acc   = 4'd3;
        cfg.t_rwr   = 4'd2;
        tx_valid    = 1'b0;
        tx_data     = '0;
        tx_mask     = '0;
        rx_ready    = 1'b1;
        extra_lat   = 1'b0;
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = 16'(i * 16'h1357) ^ 16'hc3a5;
        end
        repeat (5) @(negedge clk0);
        rst_ni = 1'b1;
        @(negedge clk0);
        check("reset_ready_cs", 2'b11, {trans_ready, cs_n});
        check("reset_outputs", 5'b0, {ck_en, dq_oe, tx_ready, rx_valid, b_valid});

        for (int t = 0; t < N_TRANS / 2; t++) begin
            addr      = $random(seed);
            len       = 1 + $unsigned($random(seed)) % 8;
            extra_lat = 1'($random(seed));
            write_burst(addr, len);
            extra_lat = 1'($random(seed));
            read_burst(addr, len);
        end

        repeat (4) @(negedge clk0);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hyper_pkg.sv
hyper_seq.sv
hyper_tx.sv
hyper_rx.sv
hyper_ctrl.sv
tb_clk_gen.sv
hyper_ram_model.sv
tb_hyper.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_hyper -f tb.f -o sim_hyper

./obj_dir/sim_hyper | tee sim.log

grep -q "Simulation passed" sim.log
